//--- rtl/calc_bypass.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operand forwarding from in-flight completion stages into the
// dispatched instruction, youngest producer first
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module calc_bypass
  import calc_cfg_pkg::*;
  import calc_pkt_pkg::*;
 #(parameter int data_width_p = 32)
 (input calc_dispatch_pkt_s                   dispatch_pkt_i
  , input calc_wb_pkt_s [PIPE_STAGE_ELS-1:0]  comp_stage_i
  , input calc_wb_pkt_s [PIPE_STAGE_ELS-1:0]  comp_next_i
  , output logic [data_width_p-1:0]           rs1_o
  , output logic [data_width_p-1:0]           rs2_o
  );

  logic [1:0][REG_ADDR_W-1:0]   src_addr;
  logic [1:0][data_width_p-1:0] src_data;
  logic [1:0][data_width_p-1:0] bypass_rs;

  assign src_addr = {dispatch_pkt_i.rs2_addr, dispatch_pkt_i.rs1_addr};
  assign src_data = {dispatch_pkt_i.rs2[data_width_p-1:0], dispatch_pkt_i.rs1[data_width_p-1:0]};

  for (genvar s = 0; s < 2; s++)
  begin : src
    logic [PIPE_STAGE_ELS-1:0] match;

    for (genvar i = 0; i < PIPE_STAGE_ELS; i++)
    begin : stage
      assign match[i] = comp_stage_i[i].rd_w_v & (comp_stage_i[i].rd_addr == src_addr[s]);
    end

    // Oldest first so the youngest match is applied last
    always_comb
    begin
      bypass_rs[s] = src_data[s];
      for (int i = PIPE_STAGE_ELS-1; i >= 0; i--)
      begin
        if (match[i])
          bypass_rs[s] = comp_next_i[i].rd_data[data_width_p-1:0];
      end
    end
  end

  assign rs1_o = bypass_rs[0];
  assign rs2_o = bypass_rs[1];

endmodule

//--- rtl/calc_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and completion pipeline depths shared by the execution core
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package calc_cfg_pkg;

  // Widest datapath the packet structs can carry
  localparam int DATA_W_MAX = 64;

  localparam int REG_ADDR_W = 5;

  // Completion stages, the last one drives the writeback port
  localparam int PIPE_STAGE_ELS = 4;

  // Stages where fixed-latency results join the completion pipe
  localparam int INT_STAGE = 1;
  localparam int MUL_STAGE = 3;

endpackage

//--- rtl/calc_ctl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reservation register, completion pipeline and writeback arbitration.
// Fixed-latency results merge into the pipe and long results take the
// writeback port when the last stage has no write
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module calc_ctl
  import calc_cfg_pkg::*;
  import calc_pkt_pkg::*;
 #(parameter int data_width_p = 32)
 (input                                         clk_i
  , input                                       reset_i

  , input calc_dispatch_pkt_s                   dispatch_pkt_i
  , input [data_width_p-1:0]                    bypass_rs1_i
  , input [data_width_p-1:0]                    bypass_rs2_i
  , output calc_dispatch_pkt_s                  reservation_o

  , output calc_wb_pkt_s [PIPE_STAGE_ELS-1:0]   comp_stage_o
  , output calc_wb_pkt_s [PIPE_STAGE_ELS-1:0]   comp_next_o

  , input [data_width_p-1:0]                    int_data_i
  , input                                       int_v_i
  , input [data_width_p-1:0]                    mul_data_i
  , input                                       mul_v_i

  , input calc_wb_pkt_s                         long_wb_pkt_i
  , input                                       long_v_i
  , output logic                                long_yumi_o

  , output calc_wb_pkt_s                        iwb_pkt_o
  );

  calc_dispatch_pkt_s reservation_n, reservation_r;
  calc_wb_pkt_s [PIPE_STAGE_ELS:0]   comp_stage_n;
  calc_wb_pkt_s [PIPE_STAGE_ELS-1:0] comp_stage_r;
  logic is_long_n;

  // Operands replaced by bypass data and writes to x0 dropped
  always_comb
  begin
    reservation_n                         = dispatch_pkt_i;
    reservation_n.rs1                     = '0;
    reservation_n.rs1[data_width_p-1:0]   = bypass_rs1_i;
    reservation_n.rs2                     = '0;
    reservation_n.rs2[data_width_p-1:0]   = bypass_rs2_i;
    reservation_n.rd_w_v                  = dispatch_pkt_i.v & dispatch_pkt_i.rd_w_v
                                            & (dispatch_pkt_i.rd_addr != '0);
  end

  assign is_long_n = reservation_n.op inside {e_op_div, e_op_rem};

  always_ff @(posedge clk_i)
  begin
    reservation_r <= reservation_n;
    if (reset_i)
    begin
      reservation_r.v      <= 1'b0;
      reservation_r.rd_w_v <= 1'b0;
    end
  end

  always_comb
  begin
    // Divides write back late, so their entry carries no write
    comp_stage_n[0].rd_w_v  = reservation_n.rd_w_v & ~is_long_n;
    comp_stage_n[0].rd_addr = reservation_n.rd_addr;
    comp_stage_n[0].rd_data = '0;
    for (int i = 1; i <= PIPE_STAGE_ELS; i++)
    begin
      comp_stage_n[i] = comp_stage_r[i-1];
    end
    comp_stage_n[INT_STAGE].rd_data[data_width_p-1:0] |= int_v_i ? int_data_i : '0;
    comp_stage_n[MUL_STAGE].rd_data[data_width_p-1:0] |= mul_v_i ? mul_data_i : '0;
  end

  always_ff @(posedge clk_i)
  begin
    comp_stage_r <= comp_stage_n[PIPE_STAGE_ELS-1:0];
    if (reset_i)
    begin
      for (int i = 0; i < PIPE_STAGE_ELS; i++)
      begin
        comp_stage_r[i].rd_w_v <= 1'b0;
      end
    end
  end

  assign long_yumi_o = long_v_i & ~comp_stage_r[PIPE_STAGE_ELS-1].rd_w_v;
  assign iwb_pkt_o   = long_yumi_o ? long_wb_pkt_i : comp_stage_r[PIPE_STAGE_ELS-1];

  assign reservation_o = reservation_r;
  assign comp_stage_o  = comp_stage_r;
  assign comp_next_o   = comp_stage_n[PIPE_STAGE_ELS:1];

  // ALU and multiplier results never arrive in the same cycle
  assert property (@(posedge clk_i) disable iff (reset_i) !(int_v_i && mul_v_i));

  // A refused late result is held unchanged into the next cycle
  assert property (@(posedge clk_i) disable iff (reset_i)
    long_v_i && !long_yumi_o |=> long_v_i && $stable(long_wb_pkt_i));

endmodule

//--- rtl/calc_pipe_int.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer ALU, result ready in the same cycle as the reservation
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module calc_pipe_int
  import calc_pkt_pkg::*;
 #(parameter int data_width_p = 32)
 (input calc_dispatch_pkt_s          reservation_i
  , output logic [data_width_p-1:0]  data_o
  , output logic                     v_o
  );

  localparam int shamt_w_lp = $clog2(data_width_p);

  wire [data_width_p-1:0] src1 = reservation_i.rs1[data_width_p-1:0];
  wire [data_width_p-1:0] src2 = reservation_i.rs2[data_width_p-1:0];
  wire [shamt_w_lp-1:0]   shamt = src2[shamt_w_lp-1:0];

  logic alu_op;

  always_comb
  begin
    alu_op = 1'b1;
    data_o = '0;
    case (reservation_i.op)
      e_op_add: data_o = src1 + src2;
      e_op_sub: data_o = src1 - src2;
      e_op_and: data_o = src1 & src2;
      e_op_or:  data_o = src1 | src2;
      e_op_xor: data_o = src1 ^ src2;
      e_op_sll: data_o = src1 << shamt;
      e_op_srl: data_o = src1 >> shamt;
      e_op_slt: data_o[0] = ($signed(src1) < $signed(src2));
      // mul, div and rem belong to the other pipes
      default:  alu_op = 1'b0;
    endcase
  end

  assign v_o = reservation_i.v & alu_op;

endmodule

//--- rtl/calc_pipe_long.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Iterative unsigned divide and remainder. One quotient bit per cycle,
// result held until the writeback slot accepts it with yumi
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module calc_pipe_long
  import calc_cfg_pkg::*;
  import calc_pkt_pkg::*;
 #(parameter int data_width_p = 32)
 (input                          clk_i
  , input                        reset_i
  , input calc_dispatch_pkt_s    reservation_i
  , output logic                 ready_o
  , output calc_wb_pkt_s         wb_pkt_o
  , output logic                 v_o
  , input                        yumi_i
  );

  localparam int cnt_w_lp = $clog2(data_width_p);

  logic start;
  logic busy_r, done_r;
  logic last_iter;
  logic [cnt_w_lp-1:0] cnt_r;
  logic rem_sel_r, rd_w_v_r;
  logic [REG_ADDR_W-1:0] rd_addr_r;
  logic [data_width_p-1:0] divisor_r, quo_r, rem_r;
  logic [data_width_p:0] rem_shift, trial;

  assign start     = reservation_i.v & (reservation_i.op inside {e_op_div, e_op_rem});
  assign last_iter = busy_r & (cnt_r == cnt_w_lp'(data_width_p-1));

  // Trial subtract, a borrow keeps the shifted remainder
  assign rem_shift = {rem_r, quo_r[data_width_p-1]};
  assign trial     = rem_shift - {1'b0, divisor_r};

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      busy_r <= 1'b0;
      done_r <= 1'b0;
    end
    else if (start)
      busy_r <= 1'b1;
    else if (last_iter)
    begin
      busy_r <= 1'b0;
      done_r <= 1'b1;
    end
    else if (yumi_i)
      done_r <= 1'b0;
  end

  // A zero divisor never borrows, giving all ones and the dividend back
  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      divisor_r <= reservation_i.rs2[data_width_p-1:0];
      quo_r     <= reservation_i.rs1[data_width_p-1:0];
      rem_r     <= '0;
      cnt_r     <= '0;
      rem_sel_r <= (reservation_i.op == e_op_rem);
      rd_addr_r <= reservation_i.rd_addr;
      rd_w_v_r  <= reservation_i.rd_w_v;
    end
    else if (busy_r)
    begin
      cnt_r <= cnt_r + 1'b1;
      if (trial[data_width_p])
      begin
        rem_r <= rem_shift[data_width_p-1:0];
        quo_r <= {quo_r[data_width_p-2:0], 1'b0};
      end
      else
      begin
        rem_r <= trial[data_width_p-1:0];
        quo_r <= {quo_r[data_width_p-2:0], 1'b1};
      end
    end
  end

  always_comb
  begin
    wb_pkt_o                            = '0;
    wb_pkt_o.rd_w_v                     = rd_w_v_r;
    wb_pkt_o.rd_addr                    = rd_addr_r;
    wb_pkt_o.rd_data[data_width_p-1:0]  = rem_sel_r ? rem_r : quo_r;
  end

  assign v_o     = done_r;
  assign ready_o = ~busy_r & ~done_r & ~start;

  // A divide only enters when the dispatcher saw the unit ready
  assert property (@(posedge clk_i) disable iff (reset_i) start |-> $past(ready_o));

  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o);

endmodule

//--- rtl/calc_pipe_mul.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-stage multiplier returning the low half of the product, two
// cycles after the operation sits in the reservation register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module calc_pipe_mul
  import calc_pkt_pkg::*;
 #(parameter int data_width_p = 32)
 (input                              clk_i
  , input                            reset_i
  , input calc_dispatch_pkt_s        reservation_i
  , output logic [data_width_p-1:0]  data_o
  , output logic                     v_o
  );

  logic is_mul;
  logic v1_r, v2_r;
  logic [data_width_p-1:0] a_r, b_r, prod_r;

  assign is_mul = reservation_i.v & (reservation_i.op == e_op_mul);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v1_r <= 1'b0;
      v2_r <= 1'b0;
    end
    else
    begin
      v1_r <= is_mul;
      v2_r <= v1_r;
    end
  end

  // Low half is the same for signed and unsigned operands
  always_ff @(posedge clk_i)
  begin
    a_r    <= reservation_i.rs1[data_width_p-1:0];
    b_r    <= reservation_i.rs2[data_width_p-1:0];
    prod_r <= $signed(a_r) * $signed(b_r);
  end

  assign data_o = prod_r;
  assign v_o    = v2_r;

  assert property (@(posedge clk_i) disable iff (reset_i) v_o == $past(is_mul, 2));

endmodule

//--- rtl/calc_pkt_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Operation codes and the dispatch and writeback packets passed
// between the control block and the execution pipes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package calc_pkt_pkg;
  import calc_cfg_pkg::*;

  typedef enum logic [3:0]
  {
    e_op_add = 4'h0,
    e_op_sub = 4'h1,
    e_op_and = 4'h2,
    e_op_or  = 4'h3,
    e_op_xor = 4'h4,
    e_op_sll = 4'h5,
    e_op_srl = 4'h6,
    e_op_slt = 4'h7,
    e_op_mul = 4'h8,
    e_op_div = 4'h9,
    e_op_rem = 4'ha
  } calc_op_e;

  // Data fields use the low data_width_p bits, upper bits stay zero
  typedef struct packed
  {
    logic                  v;
    calc_op_e              op;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [DATA_W_MAX-1:0] rs1;
    logic [DATA_W_MAX-1:0] rs2;
    logic                  rd_w_v;
  } calc_dispatch_pkt_s;

  typedef struct packed
  {
    logic                  rd_w_v;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [DATA_W_MAX-1:0] rd_data;
  } calc_wb_pkt_s;

endpackage

//--- rtl/calc_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execution core top level. Takes decoded instructions with operands
// and returns integer register writes on a single writeback port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module calc_top
  import calc_cfg_pkg::*;
  import calc_pkt_pkg::*;
 #(parameter int data_width_p = 32)
 (input                       clk_i
  , input                     reset_i

  , input calc_dispatch_pkt_s dispatch_pkt_i
  , output logic              long_ready_o
  , output calc_wb_pkt_s      iwb_pkt_o
  );

  calc_dispatch_pkt_s reservation;
  calc_wb_pkt_s [PIPE_STAGE_ELS-1:0] comp_stage, comp_next;
  calc_wb_pkt_s long_wb_pkt;

  logic [data_width_p-1:0] bypass_rs1, bypass_rs2;
  logic [data_width_p-1:0] int_data, mul_data;
  logic int_v, mul_v, long_v, long_yumi;

  calc_ctl
   #(.data_width_p(data_width_p))
   ctl
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.dispatch_pkt_i(dispatch_pkt_i)
     ,.bypass_rs1_i(bypass_rs1)
     ,.bypass_rs2_i(bypass_rs2)
     ,.reservation_o(reservation)
     ,.comp_stage_o(comp_stage)
     ,.comp_next_o(comp_next)
     ,.int_data_i(int_data)
     ,.int_v_i(int_v)
     ,.mul_data_i(mul_data)
     ,.mul_v_i(mul_v)
     ,.long_wb_pkt_i(long_wb_pkt)
     ,.long_v_i(long_v)
     ,.long_yumi_o(long_yumi)
     ,.iwb_pkt_o(iwb_pkt_o)
     );

  calc_bypass
   #(.data_width_p(data_width_p))
   bypass
    (.dispatch_pkt_i(dispatch_pkt_i)
     ,.comp_stage_i(comp_stage)
     ,.comp_next_i(comp_next)
     ,.rs1_o(bypass_rs1)
     ,.rs2_o(bypass_rs2)
     );

  // Single cycle ALU
  calc_pipe_int
   #(.data_width_p(data_width_p))
   pipe_int
    (.reservation_i(reservation)
     ,.data_o(int_data)
     ,.v_o(int_v)
     );

  calc_pipe_mul
   #(.data_width_p(data_width_p))
   pipe_mul
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.reservation_i(reservation)
     ,.data_o(mul_data)
     ,.v_o(mul_v)
     );

  // Divider writes back late through the arbitrated slot
  calc_pipe_long
   #(.data_width_p(data_width_p))
   pipe_long
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.reservation_i(reservation)
     ,.ready_o(long_ready_o)
     ,.wb_pkt_o(long_wb_pkt)
     ,.v_o(long_v)
     ,.yumi_i(long_yumi)
     );

endmodule

//--- src.f
rtl/calc_cfg_pkg.sv
rtl/calc_pkt_pkg.sv
rtl/calc_pipe_int.sv
rtl/calc_pipe_mul.sv
rtl/calc_pipe_long.sv
rtl/calc_bypass.sv
rtl/calc_ctl.sv
rtl/calc_top.sv
+incdir+include
tb/tb_calc.sv

//--- include/calc_tb_vectors.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction vectors for the execution core testbench, included in
// the testbench module and applied in order, grouped by test number
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef CALC_TB_VECTORS_SVH
`define CALC_TB_VECTORS_SVH

// Columns: test, op, rs1, rs2, rd, extra repeats, idle cycles after
typedef struct packed
{
  logic [2:0]            test;
  calc_op_e              op;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [7:0]            rep;
  logic [3:0]            idle;
} vec_s;

localparam int vec_count = 30;

localparam vec_s vec_table [vec_count] = '{
  '{3'd1, e_op_add, 5'd1,  5'd2,  5'd21, 8'd0,  4'd0},
  '{3'd1, e_op_sub, 5'd3,  5'd4,  5'd22, 8'd0,  4'd0},
  '{3'd1, e_op_and, 5'd5,  5'd6,  5'd23, 8'd0,  4'd0},
  '{3'd1, e_op_or,  5'd7,  5'd8,  5'd24, 8'd0,  4'd0},
  '{3'd1, e_op_xor, 5'd9,  5'd10, 5'd25, 8'd0,  4'd0},
  '{3'd1, e_op_sll, 5'd11, 5'd12, 5'd26, 8'd0,  4'd0},
  '{3'd1, e_op_srl, 5'd13, 5'd14, 5'd27, 8'd0,  4'd0},
  '{3'd1, e_op_slt, 5'd15, 5'd16, 5'd28, 8'd0,  4'd0},
  '{3'd1, e_op_slt, 5'd16, 5'd15, 5'd29, 8'd0,  4'd0},
  // Chains at distance 1, 2 and 3, then two writes to x9 in flight
  '{3'd2, e_op_add, 5'd1,  5'd2,  5'd5,  8'd0,  4'd0},
  '{3'd2, e_op_sub, 5'd5,  5'd3,  5'd6,  8'd0,  4'd0},
  '{3'd2, e_op_xor, 5'd5,  5'd6,  5'd7,  8'd0,  4'd0},
  '{3'd2, e_op_and, 5'd5,  5'd7,  5'd8,  8'd0,  4'd0},
  '{3'd2, e_op_add, 5'd1,  5'd1,  5'd9,  8'd0,  4'd0},
  '{3'd2, e_op_add, 5'd2,  5'd3,  5'd9,  8'd0,  4'd0},
  '{3'd2, e_op_sub, 5'd9,  5'd1,  5'd10, 8'd0,  4'd3},
  // Product is forwarded only from the merge stage onward
  '{3'd3, e_op_mul, 5'd1,  5'd2,  5'd11, 8'd0,  4'd2},
  '{3'd3, e_op_add, 5'd11, 5'd3,  5'd12, 8'd0,  4'd0},
  '{3'd3, e_op_mul, 5'd12, 5'd12, 5'd13, 8'd0,  4'd2},
  '{3'd3, e_op_sub, 5'd13, 5'd11, 5'd14, 8'd0,  4'd0},
  '{3'd4, e_op_div, 5'd1,  5'd27, 5'd15, 8'd0,  4'd0},
  '{3'd4, e_op_rem, 5'd1,  5'd27, 5'd16, 8'd0,  4'd0},
  '{3'd4, e_op_div, 5'd2,  5'd0,  5'd17, 8'd0,  4'd0},
  '{3'd4, e_op_rem, 5'd2,  5'd0,  5'd18, 8'd0,  4'd0},
  '{3'd4, e_op_add, 5'd15, 5'd16, 5'd19, 8'd0,  4'd0},
  // Divide under a continuous stream of ALU writes
  '{3'd5, e_op_div, 5'd4,  5'd5,  5'd20, 8'd0,  4'd0},
  '{3'd5, e_op_add, 5'd9,  5'd10, 5'd9,  8'd39, 4'd0},
  '{3'd6, e_op_add, 5'd1,  5'd2,  5'd0,  8'd0,  4'd0},
  '{3'd6, e_op_mul, 5'd3,  5'd4,  5'd0,  8'd0,  4'd2},
  '{3'd6, e_op_div, 5'd5,  5'd6,  5'd0,  8'd0,  4'd0}
};

localparam string test_names [7] = '{
  "register load", "alu ops", "forwarding", "multiply",
  "divide", "late writeback", "x0 writes"
};

`endif

//--- tb/tb_calc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the execution core. Loads the register file through
// the DUT, applies the vector table and checks every writeback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_calc
  import calc_cfg_pkg::*;
  import calc_pkt_pkg::*;
 ();

  localparam int data_w = 32;

  `include "calc_tb_vectors.svh"

  localparam int watchdog_cycles = (vec_count + 32) * (data_w + 10);

  typedef struct
  {
    int                    due;
    logic [REG_ADDR_W-1:0] rd;
    logic [data_w-1:0]     data;
  } exp_s;

  logic clk = 1'b0;
  logic reset;
  calc_dispatch_pkt_s dispatch_pkt;
  logic long_ready;
  calc_wb_pkt_s iwb_pkt;

  // arch_rf follows program order and wb_rf holds only what has been written back
  logic [data_w-1:0] arch_rf [32];
  logic [data_w-1:0] wb_rf [32];
  exp_s exp_q [$];

  int cyc = 0;
  int seed = 32'h5861;
  int checks = 0;
  int writes = 0;
  int errors = 0;
  int test_writes0 = 0;
  int test_errors0 = 0;
  int ready_low_cyc = -1;
  int ready_high_cyc = -1;
  logic long_pending = 1'b0;
  logic [REG_ADDR_W-1:0] long_rd = '0;
  logic [data_w-1:0] long_exp_data;

  calc_top
   #(.data_width_p(data_w))
   dut_i
    (.clk_i(clk)
     ,.reset_i(reset)
     ,.dispatch_pkt_i(dispatch_pkt)
     ,.long_ready_o(long_ready)
     ,.iwb_pkt_o(iwb_pkt)
     );

  always #2 clk = ~clk;

  always @(posedge clk)
    cyc <= cyc + 1;

  function automatic logic is_long_op(input calc_op_e op);
    return op inside {e_op_div, e_op_rem};
  endfunction

  function automatic logic [data_w-1:0] expected_result(input calc_op_e op,
                                                        input logic [data_w-1:0] a,
                                                        input logic [data_w-1:0] b);
    case (op)
      e_op_add: return a + b;
      e_op_sub: return a - b;
      e_op_and: return a & b;
      e_op_or:  return a | b;
      e_op_xor: return a ^ b;
      e_op_sll: return a << b[$clog2(data_w)-1:0];
      e_op_srl: return a >> b[$clog2(data_w)-1:0];
      e_op_slt: return data_w'($signed(a) < $signed(b));
      e_op_mul: return a * b;
      e_op_div: return (b == '0) ? '1 : a / b;
      e_op_rem: return (b == '0) ? a : a % b;
      default:  return '0;
    endcase
  endfunction

  // Upstream scoreboard duty for a divide still in flight
  function automatic logic long_hazard(input vec_s v);
    return is_long_op(v.op) || v.rs1 == long_rd || v.rs2 == long_rd || v.rd == long_rd;
  endfunction

  task automatic report_mismatch(input string name, input logic [DATA_W_MAX-1:0] expected,
                                 input logic [DATA_W_MAX-1:0] actual);
    $display("error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    dispatch_pkt = '0;
  endtask

  task automatic issue(input calc_op_e op, input logic [REG_ADDR_W-1:0] a,
                       input logic [REG_ADDR_W-1:0] b, input logic [REG_ADDR_W-1:0] d,
                       input logic [data_w-1:0] da, input logic [data_w-1:0] db,
                       input logic [data_w-1:0] xa, input logic [data_w-1:0] xb);
    logic [data_w-1:0] res;
    res = expected_result(op, xa, xb);
    dispatch_pkt = '0;
    dispatch_pkt.v = 1'b1;
    dispatch_pkt.op = op;
    dispatch_pkt.rs1_addr = a;
    dispatch_pkt.rs2_addr = b;
    dispatch_pkt.rd_addr = d;
    dispatch_pkt.rs1[data_w-1:0] = da;
    dispatch_pkt.rs2[data_w-1:0] = db;
    dispatch_pkt.rd_w_v = 1'b1;
    if (is_long_op(op))
    begin
      long_rd = d;
      ready_low_cyc = cyc + 1;
      if (d != '0)
      begin
        long_pending = 1'b1;
        long_exp_data = res;
      end
    end
    else if (d != '0)
      exp_q.push_back('{due: cyc + 4, rd: d, data: res});
    if (d != '0)
      arch_rf[d] = res;
  endtask

  task automatic apply_vector(input vec_s v);
    for (int r = 0; r <= int'(v.rep); r++)
    begin
      next_cycle();
      while (long_hazard(v) && !long_ready)
        next_cycle();
      issue(v.op, v.rs1, v.rs2, v.rd, wb_rf[v.rs1], wb_rf[v.rs2], arch_rf[v.rs1],
            arch_rf[v.rs2]);
    end
    repeat (v.idle) next_cycle();
  endtask

  task automatic finish_test(input int n);
    while (exp_q.size() != 0 || long_pending || !long_ready)
      next_cycle();
    repeat (2) next_cycle();
    $display("test %0d %s: %0d writes, %0d errors", n, test_names[n],
             writes - test_writes0, errors - test_errors0);
    test_writes0 = writes;
    test_errors0 = errors;
  endtask

  // Fixed-latency writes are due in one exact cycle and the divide fills a free one
  task automatic check_cycle();
    exp_s entry;
    checks++;
    if (exp_q.size() != 0 && exp_q[0].due == cyc)
    begin
      entry = exp_q.pop_front();
      assert (iwb_pkt.rd_w_v)
      else
      begin
        $display("error at %0t: write to x%0d due in this cycle did not appear", $time,
                 entry.rd);
        errors++;
      end
      if (iwb_pkt.rd_w_v)
      begin
        assert (iwb_pkt.rd_addr == entry.rd)
        else report_mismatch("iwb_pkt_o.rd_addr", entry.rd, iwb_pkt.rd_addr);
        assert (iwb_pkt.rd_data == DATA_W_MAX'(entry.data))
        else report_mismatch("iwb_pkt_o.rd_data", entry.data, iwb_pkt.rd_data);
      end
      wb_rf[entry.rd] = entry.data;
      writes++;
    end
    else if (iwb_pkt.rd_w_v)
    begin
      assert (long_pending)
      else
      begin
        $display("error at %0t: unexpected write to x%0d", $time, iwb_pkt.rd_addr);
        errors++;
      end
      if (long_pending)
      begin
        assert (iwb_pkt.rd_addr == long_rd)
        else report_mismatch("iwb_pkt_o.rd_addr", long_rd, iwb_pkt.rd_addr);
        assert (iwb_pkt.rd_data == DATA_W_MAX'(long_exp_data))
        else report_mismatch("iwb_pkt_o.rd_data", long_exp_data, iwb_pkt.rd_data);
        wb_rf[long_rd] = long_exp_data;
        long_pending = 1'b0;
        ready_high_cyc = cyc + 1;
        writes++;
      end
    end
    assert (!(iwb_pkt.rd_w_v && iwb_pkt.rd_addr == '0))
    else
    begin
      $display("error at %0t: a write to x0 appeared on the writeback port", $time);
      errors++;
    end
    if (cyc == ready_low_cyc)
      assert (!long_ready) else report_mismatch("long_ready_o", 1'b0, long_ready);
    if (cyc == ready_high_cyc)
      assert (long_ready) else report_mismatch("long_ready_o", 1'b1, long_ready);
  endtask

  always @(negedge clk)
  begin
    if (!reset)
      check_cycle();
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    logic [data_w-1:0] val;
    reset = 1'b1;
    dispatch_pkt = '0;
    for (int i = 0; i < 32; i++)
    begin
      arch_rf[i] = '0;
      wb_rf[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // Each register value passes through the DUT as x0 + rs2 data
    for (int k = 1; k < 32; k++)
    begin
      next_cycle();
      val = data_w'({$random(seed), $random(seed)});
      issue(e_op_add, '0, '0, k[REG_ADDR_W-1:0], '0, val, '0, val);
    end
    finish_test(0);

    for (int i = 0; i < vec_count; i++)
    begin
      apply_vector(vec_table[i]);
      if (i == vec_count - 1 || vec_table[i+1].test != vec_table[i].test)
        finish_test(int'(vec_table[i].test));
    end

    $display("%0d checks, %0d writes, %0d errors", checks, writes, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
